//--- daq_stimulus.txt
// columns: command, ADC sample, expected reply type (0 = none), expected channel index
// command F waits for the next DATA reply, a line of zeros ends the list
1 000 A F
4 000 0 F
F 123 5 0
F 456 5 1
F 789 5 2
F ABC 5 3
F 0DE 5 4
F 5A5 5 5
F 3C3 5 0
F 7FF 5 1
F 001 5 2
9 000 0 2
0 000 0 0

//--- flist.f
+incdir+.
daq_cmd_pkg.sv
daq_ctrl_pkg.sv
daq_if.sv
console_hq.sv
tick_timer.sv
adc_sampler.sv
com_frontend.sv
daq_regs.sv
daq_top.sv
daq_assert.sv
daq_tb.sv

//--- daq_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "daq_consts.svh"

module daq_tb;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic cmd_valid = 1'b0;
    logic cmd_ready;
    logic [3:0] cmd_btype = 4'h0;
    logic rsp_valid;
    logic rsp_ready = 1'b0;
    logic [3:0] rsp_btype;
    logic [3:0] rsp_chan;
    logic [`DAQ_DATA_W-1:0] rsp_data;
    logic adc_start;
    logic [3:0] adc_chan;
    logic adc_conf;
    logic adc_done = 1'b0;
    logic [`DAQ_DATA_W-1:0] adc_data = '0;
    logic awvalid = 1'b0;
    logic awready;
    logic [`DAQ_ADDR_W-1:0] awaddr = '0;
    logic wvalid = 1'b0;
    logic wready;
    logic [31:0] wdata = '0;
    logic [3:0] wstrb = 4'hF;
    logic bvalid;
    logic bready = 1'b1;
    logic [1:0] bresp;
    logic arvalid = 1'b0;
    logic arready;
    logic [`DAQ_ADDR_W-1:0] araddr = '0;
    logic rvalid;
    logic rready = 1'b1;
    logic [31:0] rdata;
    logic [1:0] rresp;

    logic [15:0] stim [0:63];
    logic [31:0] rng = 32'h4bb2_0d1f;
    logic [`DAQ_DATA_W-1:0] sample_q [$];  // values the ADC model hands out in order
    logic [3:0] got_btype_q [$];
    logic [3:0] got_chan_q [$];
    logic [`DAQ_DATA_W-1:0] got_data_q [$];
    logic [3:0] conf_chan_exp = 4'h0;  // channel field of the word in REG_CONF
    logic [3:0] conv_chan_exp = 4'h0;  // the sweep starts at channel 0
    int errors = 0;
    int timeouts = 0;

    localparam int TICK_PERIOD = 100;
    localparam int WAIT_LIMIT = 2000;
    localparam logic [7:0] CONF_WORD = 8'h32;

    daq_top dut0 (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // ****************************************
    // host and ADC models
    // ****************************************

    always @(negedge clk) begin
        if (!rst) begin
            rng = xorshift(rng);
            rsp_ready <= (rng[1:0] != 2'b00);  // roughly one stall in four
        end
    end

    always @(posedge clk) begin
        if (rsp_valid && rsp_ready) begin
            got_btype_q.push_back(rsp_btype);
            got_chan_q.push_back(rsp_chan);
            got_data_q.push_back(rsp_data);
        end
    end

    always @(posedge clk) begin
        if (adc_start) begin
            if (adc_conf) begin
                check_chan(adc_chan, conf_chan_exp, "ADC configuration channel");
                conv_chan_exp = 4'h0;  // configuration restarts the sweep
            end else begin
                check_chan(adc_chan, conv_chan_exp, "ADC conversion channel");
                conv_chan_exp = (conv_chan_exp == `DAQ_LAST_CHAN) ? 4'h0 : conv_chan_exp + 4'h1;
            end
            rng = xorshift(rng);
            repeat (1 + rng[2:0]) @(negedge clk);
            if (!adc_conf) begin
                if (sample_q.size() == 0) begin
                    $display("conversion started with no sample left in the stimulus");
                    errors++;
                    adc_data <= '0;
                end else begin
                    adc_data <= sample_q.pop_front();
                end
            end
            adc_done <= 1'b1;
            @(negedge clk);
            adc_done <= 1'b0;
        end
    end

    // ****************************************
    // report, compare and bus tasks
    // ****************************************

    task automatic finish_run();
        int assert_fails;
        assert_fails = dut0.hq0.assert0.fail_count;
        $display("checks done: %0d errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) $display("STATUS: PASS");
        else $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        timeouts++;
        finish_run();
    endtask

    task automatic check_btype(input daq_cmd_pkg::btype_e got, input daq_cmd_pkg::btype_e exp);
        if (got !== exp) begin
            $display("Error at %0t: reply type %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_chan(input logic [3:0] got, input logic [3:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input logic [`DAQ_DATA_W-1:0] got,
                              input logic [`DAQ_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: reply sample %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        int n;
        n = 0;
        @(negedge clk);
        awvalid = 1'b1;
        wvalid = 1'b1;
        awaddr = addr;
        wdata = data;
        do begin
            @(posedge clk);
            n++;
        end while (!(awready && wready) && n < WAIT_LIMIT);
        if (!(awready && wready)) timed_out("AXI write address and data");
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        n = 0;
        while (!bvalid && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!bvalid) timed_out("AXI write response");
        check_reg({30'h0, bresp}, 32'h0, "write response");
    endtask

    task automatic axi_read(input logic [3:0] addr, input logic [1:0] exp_resp,
                            output logic [31:0] data);
        int n;
        n = 0;
        @(negedge clk);
        arvalid = 1'b1;
        araddr = addr;
        do begin
            @(posedge clk);
            n++;
        end while (!arready && n < WAIT_LIMIT);
        if (!arready) timed_out("AXI read address");
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!rvalid) timed_out("AXI read data");
        data = rdata;
        check_reg({30'h0, rresp}, {30'h0, exp_resp}, "read response");
    endtask

    task automatic send_cmd(input logic [3:0] c);
        int n;
        n = 0;
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_btype = c;
        do begin
            @(posedge clk);
            n++;
        end while (!cmd_ready && n < WAIT_LIMIT);
        if (!cmd_ready) timed_out("command accept");
        @(negedge clk);
        cmd_valid = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!cmd_ready && n < WAIT_LIMIT);  // ready returns once the link is idle
        if (!cmd_ready) timed_out("command completion");
    endtask

    task automatic expect_reply(input logic [3:0] typ, input logic [3:0] chan,
                                input logic [15:0] smp);
        int n;
        n = 0;
        while (got_btype_q.size() == 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (got_btype_q.size() == 0) timed_out("reply");
        check_btype(daq_cmd_pkg::btype_e'(got_btype_q.pop_front()), daq_cmd_pkg::btype_e'(typ));
        check_chan(got_chan_q.pop_front(), chan, "reply channel");
        if (typ == daq_cmd_pkg::COM_DATA) check_data(got_data_q.pop_front(), smp[11:0]);
        else void'(got_data_q.pop_front());  // STAT carries no meaningful sample
    endtask

    task automatic expect_no_reply(input string when);
        if (got_btype_q.size() != 0) begin
            $display("unexpected reply of type %h %s", got_btype_q[0], when);
            errors++;
            got_btype_q.delete();
            got_chan_q.delete();
            got_data_q.delete();
        end
    endtask

    // ****************************************
    // main sequence
    // ****************************************

    initial begin
        int i;
        logic [31:0] rd;
        logic [3:0] c;
        $readmemh("daq_stimulus.txt", stim);
        for (i = 0; i < 16 && stim[i*4] != 16'h0; i++) begin
            if (stim[i*4] == 16'hF) sample_q.push_back(stim[i*4+1][11:0]);
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        axi_read(daq_ctrl_pkg::REG_TICK, 2'b00, rd);
        check_reg(rd, `DAQ_TICK_DEFAULT, "reset tick period");
        axi_write(daq_ctrl_pkg::REG_TICK, TICK_PERIOD);
        axi_read(daq_ctrl_pkg::REG_TICK, 2'b00, rd);
        check_reg(rd, TICK_PERIOD, "tick period read back");
        axi_write(daq_ctrl_pkg::REG_CONF, {24'h0, CONF_WORD});
        axi_read(daq_ctrl_pkg::REG_CONF, 2'b00, rd);
        check_reg(rd, {24'h0, CONF_WORD}, "configuration word read back");
        conf_chan_exp = CONF_WORD[3:0];
        axi_read(4'hC, 2'b10, rd);  // unmapped address answers SLVERR

        for (i = 0; i < 16 && stim[i*4] != 16'h0; i++) begin
            c = stim[i*4][3:0];
            if (c == 4'hF) begin
                expect_reply(stim[i*4+2][3:0], stim[i*4+3][3:0], stim[i*4+1]);
            end else begin
                send_cmd(c);
                if (c == daq_cmd_pkg::COM_STOP) begin
                    repeat (4 * TICK_PERIOD) @(posedge clk);
                end
                if (stim[i*4+2] != 16'h0) expect_reply(stim[i*4+2][3:0], stim[i*4+3][3:0], 0);
                expect_no_reply("after a command");
                axi_read(daq_ctrl_pkg::REG_STAT, 2'b00, rd);
                check_reg(rd, {27'h0, c == daq_cmd_pkg::COM_READ, stim[i*4+3][3:0]}, "status");
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- daq_assert.sv
`timescale 1ns/1ps
`default_nettype none

module daq_assert (
    input wire clk,
    input wire rst,
    input wire daq_ctrl_pkg::hq_state_e state,
    input wire tick_req,
    input wire tick_done,
    input wire read_req,
    input wire read_done,
    input wire send_req,
    input wire send_done,
    input wire conf_req,
    input wire conf_done,
    input wire conv_req,
    input wire conv_done,
    input wire [3:0] chan_idx
);

    int fail_count = 0;

    // a done only ever answers a request that is still up
    done_has_req: assert property (@(posedge clk) disable iff (rst)
        ($rose(tick_done) |-> tick_req) and ($rose(read_done) |-> read_req) and
        ($rose(send_done) |-> send_req) and ($rose(conf_done) |-> conf_req) and
        ($rose(conv_done) |-> conv_req))
        else begin
            fail_count++;
            $error("done raised without a pending request");
        end

    state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {8'h00, 8'h01, 8'h02, [8'h10:8'h13], [8'h40:8'h43],
                      [8'h50:8'h53], [8'h80:8'h83], [8'h90:8'h93]})
        else begin
            fail_count++;
            $error("sequencer state outside its enum");
        end

    chan_legal: assert property (@(posedge clk) disable iff (rst)
        !(chan_idx inside {[4'd6:4'd14]}))  // 15 is the idle marker
        else begin
            fail_count++;
            $error("channel index out of range");
        end

endmodule

bind console_hq daq_assert assert0 (
    .clk(clk), .rst(rst), .state(state),
    .tick_req(tick_req), .tick_done(tick_done),
    .read_req(com.read_req), .read_done(com.read_done),
    .send_req(com.send_req), .send_done(com.send_done),
    .conf_req(adc.conf_req), .conf_done(adc.conf_done),
    .conv_req(adc.conv_req), .conv_done(adc.conv_done),
    .chan_idx(adc.chan_idx)
);

`default_nettype wire

//--- daq_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "daq_consts.svh"

module daq_top (
    input wire clk,
    input wire rst,
    input wire cmd_valid,
    output logic cmd_ready,
    input wire [3:0] cmd_btype,
    output logic rsp_valid,
    input wire rsp_ready,
    output logic [3:0] rsp_btype,
    output logic [3:0] rsp_chan,
    output logic [`DAQ_DATA_W-1:0] rsp_data,
    output logic adc_start,
    output logic [3:0] adc_chan,
    output logic adc_conf,
    input wire adc_done,
    input wire [`DAQ_DATA_W-1:0] adc_data,
    input wire awvalid,
    output logic awready,
    input wire [`DAQ_ADDR_W-1:0] awaddr,
    input wire wvalid,
    output logic wready,
    input wire [31:0] wdata,
    input wire [3:0] wstrb,
    output logic bvalid,
    input wire bready,
    output logic [1:0] bresp,
    input wire arvalid,
    output logic arready,
    input wire [`DAQ_ADDR_W-1:0] araddr,
    output logic rvalid,
    input wire rready,
    output logic [31:0] rdata,
    output logic [1:0] rresp
);

    logic tick_req;
    logic tick_done;
    logic work;
    logic [15:0] tick_period;
    logic [7:0] conf_word;
    logic [`DAQ_DATA_W-1:0] sample;

    com_link_if com ();
    adc_ctl_if adc ();

    // ****************************************
    // blocks, mostly connected by name
    // ****************************************

    console_hq hq0 (.*);

    tick_timer timer0 (.*, .run(work), .period(tick_period));

    adc_sampler sampler0 (.*);

    com_frontend front0 (.*);

    daq_regs regs0 (.*, .chan_idx(adc.chan_idx));

endmodule

`default_nettype wire

//--- daq_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "daq_consts.svh"

module daq_regs (
    input wire clk,
    input wire rst,
    input wire awvalid,
    output logic awready,
    input wire [`DAQ_ADDR_W-1:0] awaddr,
    input wire wvalid,
    output logic wready,
    input wire [31:0] wdata,
    input wire [3:0] wstrb,
    output logic bvalid,
    input wire bready,
    output logic [1:0] bresp,
    input wire arvalid,
    output logic arready,
    input wire [`DAQ_ADDR_W-1:0] araddr,
    output logic rvalid,
    input wire rready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic [15:0] tick_period,
    output logic [7:0] conf_word,
    input wire work,
    input wire [3:0] chan_idx
);

    logic wr_ok;
    logic rd_fire;

    // address and data are taken in the same cycle, the response follows one later
    assign awready = awvalid && wvalid && !bvalid;
    assign wready = awready;
    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;
    assign wr_ok = (awaddr == daq_ctrl_pkg::REG_TICK) || (awaddr == daq_ctrl_pkg::REG_CONF);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp <= 2'b00;
            tick_period <= 16'(`DAQ_TICK_DEFAULT);
            conf_word <= 8'h00;
        end else begin
            if (bvalid && bready) bvalid <= 1'b0;
            if (awready) begin
                bvalid <= 1'b1;
                bresp <= wr_ok ? 2'b00 : 2'b10;  // SLVERR outside the writable pair
                if (awaddr == daq_ctrl_pkg::REG_TICK) begin
                    if (wstrb[0]) tick_period[7:0] <= wdata[7:0];
                    if (wstrb[1]) tick_period[15:8] <= wdata[15:8];
                end
                if (awaddr == daq_ctrl_pkg::REG_CONF && wstrb[0]) conf_word <= wdata[7:0];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
            rresp <= 2'b00;
            rdata <= 32'h0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
            rresp <= 2'b00;
            case (araddr)
                daq_ctrl_pkg::REG_TICK: rdata <= {16'h0, tick_period};
                daq_ctrl_pkg::REG_CONF: rdata <= {24'h0, conf_word};
                daq_ctrl_pkg::REG_STAT: rdata <= {27'h0, work, chan_idx};  // work sits in bit 4
                default: begin
                    rdata <= 32'h0;
                    rresp <= 2'b10;
                end
            endcase
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- com_frontend.sv
`timescale 1ns/1ps
`default_nettype none
`include "daq_consts.svh"

module com_frontend (
    input wire clk,
    input wire rst,
    com_link_if.frontend com,
    input wire cmd_valid,
    output logic cmd_ready,
    input wire [3:0] cmd_btype,
    output logic rsp_valid,
    input wire rsp_ready,
    output logic [3:0] rsp_btype,
    output logic [3:0] rsp_chan,
    output logic [`DAQ_DATA_W-1:0] rsp_data,
    input wire [`DAQ_DATA_W-1:0] sample
);

    logic rsp_load;

    // ****************************************
    // host command into the read link
    // ****************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_ready <= 1'b0;
            com.read_req <= 1'b0;
            com.read_btype <= daq_cmd_pkg::COM_INIT;
        end else begin
            // one command at a time, the next only after done has dropped
            cmd_ready <= !com.read_req && !com.read_done && !(cmd_valid && cmd_ready);
            if (cmd_valid && cmd_ready) begin
                com.read_req <= 1'b1;
                com.read_btype <= daq_cmd_pkg::btype_e'(cmd_btype);
            end else if (com.read_done) begin
                com.read_req <= 1'b0;
            end
        end
    end

    // ****************************************
    // send link out to the host reply
    // ****************************************

    assign rsp_load = com.send_req && !rsp_valid && !com.send_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            com.send_done <= 1'b0;
        end else begin
            if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
                com.send_done <= 1'b1;  // done only once the host has the word
            end else if (rsp_load) begin
                rsp_valid <= 1'b1;
            end
            if (com.send_done && !com.send_req) com.send_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_load) begin
            rsp_btype <= com.send_btype;
            rsp_chan <= com.send_chan;
            rsp_data <= sample;
        end
    end

endmodule

`default_nettype wire

//--- adc_sampler.sv
`timescale 1ns/1ps
`default_nettype none
`include "daq_consts.svh"

module adc_sampler (
    input wire clk,
    input wire rst,
    adc_ctl_if.sampler adc,
    input wire [7:0] conf_word,
    output logic adc_start,
    output logic adc_conf,
    output logic [3:0] adc_chan,
    input wire adc_done,
    input wire [`DAQ_DATA_W-1:0] adc_data,
    output logic [`DAQ_DATA_W-1:0] sample
);

    typedef enum logic [1:0] {S_IDLE, S_BUSY, S_DONE} smp_state_e;
    smp_state_e state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            adc_start <= 1'b0;
            adc_conf <= 1'b0;
            adc_chan <= 4'h0;
            adc.conf_done <= 1'b0;
            adc.conv_done <= 1'b0;
        end else begin
            adc_start <= 1'b0;
            case (state)
                S_IDLE: if (adc.conf_req || adc.conv_req) begin
                    adc_start <= 1'b1;
                    adc_conf <= adc.conf_req;
                    // the configuration word carries its channel in the low nibble
                    adc_chan <= adc.conf_req ? conf_word[3:0] : adc.chan_idx;
                    state <= S_BUSY;
                end
                S_BUSY: if (adc_done) begin
                    adc.conf_done <= adc_conf;
                    adc.conv_done <= !adc_conf;
                    state <= S_DONE;
                end
                S_DONE: if (!adc.conf_req && !adc.conv_req) begin
                    adc.conf_done <= 1'b0;
                    adc.conv_done <= 1'b0;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_BUSY && adc_done && !adc_conf) sample <= adc_data;
    end

endmodule

`default_nettype wire

//--- tick_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tick_timer (
    input wire clk,
    input wire rst,
    input wire run,
    input wire [15:0] period,
    output logic tick_req,
    input wire tick_done
);

    logic [15:0] count;
    logic [15:0] limit;

    assign limit = (period == 16'd0) ? 16'd1 : period;  // zero behaves like one

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= 16'd0;
            tick_req <= 1'b0;
        end else if (tick_req) begin
            if (tick_done) tick_req <= 1'b0;
        end else if (!run) begin
            count <= 16'd0;
        end else if (!tick_done) begin  // hold until the console drops done
            if (count >= limit - 16'd1) begin
                tick_req <= 1'b1;
                count <= 16'd0;
            end else begin
                count <= count + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- console_hq.sv
`timescale 1ns/1ps
`default_nettype none
`include "daq_consts.svh"

module console_hq (
    input wire clk,
    input wire rst,
    com_link_if.console com,
    adc_ctl_if.console adc,
    input wire tick_req,
    output logic tick_done,
    output logic work
);

    daq_ctrl_pkg::hq_state_e state;
    daq_ctrl_pkg::hq_state_e next_state;
    daq_ctrl_pkg::hq_state_e state_goto;  // where MAIN_DOOR leads next
    logic busy;

    // new events wait until every request of our own has come back
    assign busy = com.send_req | adc.conf_req | adc.conv_req;

    assign com.read_done = (state == daq_ctrl_pkg::READ_DONE);
    assign tick_done = (state == daq_ctrl_pkg::TICK_DONE);
    assign com.send_chan = adc.chan_idx;

    // ****************************************
    // state sequencing
    // ****************************************

    always_comb begin
        next_state = state;
        case (state)
            daq_ctrl_pkg::MAIN_IDLE: next_state = daq_ctrl_pkg::MAIN_WAIT;
            daq_ctrl_pkg::MAIN_WAIT: begin
                if (!busy && com.read_req) next_state = daq_ctrl_pkg::READ_IDLE;
                else if (!busy && tick_req) next_state = daq_ctrl_pkg::TICK_IDLE;
                else if (com.send_done) next_state = daq_ctrl_pkg::SEND_DONE;
                else if (adc.conf_done) next_state = daq_ctrl_pkg::CONF_DONE;
                else if (adc.conv_done) next_state = daq_ctrl_pkg::CONV_DONE;
            end
            daq_ctrl_pkg::MAIN_DOOR: next_state = state_goto;

            daq_ctrl_pkg::READ_IDLE: next_state = daq_ctrl_pkg::READ_WAIT;
            daq_ctrl_pkg::READ_WAIT: next_state = daq_ctrl_pkg::READ_WORK;
            daq_ctrl_pkg::READ_WORK: next_state = daq_ctrl_pkg::READ_DONE;
            daq_ctrl_pkg::READ_DONE: if (!com.read_req) next_state = daq_ctrl_pkg::MAIN_DOOR;

            daq_ctrl_pkg::TICK_IDLE: next_state = daq_ctrl_pkg::TICK_WAIT;
            daq_ctrl_pkg::TICK_WAIT: next_state = daq_ctrl_pkg::TICK_WORK;
            daq_ctrl_pkg::TICK_WORK: next_state = daq_ctrl_pkg::TICK_DONE;
            daq_ctrl_pkg::TICK_DONE: if (!tick_req) next_state = daq_ctrl_pkg::MAIN_DOOR;

            // outgoing requests are raised in WORK and answered back in MAIN_WAIT
            daq_ctrl_pkg::SEND_IDLE: next_state = daq_ctrl_pkg::SEND_WAIT;
            daq_ctrl_pkg::SEND_WAIT: next_state = daq_ctrl_pkg::SEND_WORK;
            daq_ctrl_pkg::SEND_WORK: next_state = daq_ctrl_pkg::MAIN_WAIT;
            daq_ctrl_pkg::SEND_DONE: if (!com.send_done) next_state = daq_ctrl_pkg::MAIN_DOOR;

            daq_ctrl_pkg::CONF_IDLE: next_state = daq_ctrl_pkg::CONF_WAIT;
            daq_ctrl_pkg::CONF_WAIT: next_state = daq_ctrl_pkg::CONF_WORK;
            daq_ctrl_pkg::CONF_WORK: next_state = daq_ctrl_pkg::MAIN_WAIT;
            daq_ctrl_pkg::CONF_DONE: if (!adc.conf_done) next_state = daq_ctrl_pkg::MAIN_DOOR;

            daq_ctrl_pkg::CONV_IDLE: next_state = daq_ctrl_pkg::CONV_WAIT;
            daq_ctrl_pkg::CONV_WAIT: next_state = daq_ctrl_pkg::CONV_WORK;
            daq_ctrl_pkg::CONV_WORK: next_state = daq_ctrl_pkg::MAIN_WAIT;
            daq_ctrl_pkg::CONV_DONE: if (!adc.conv_done) next_state = daq_ctrl_pkg::MAIN_DOOR;

            default: next_state = daq_ctrl_pkg::MAIN_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= daq_ctrl_pkg::MAIN_IDLE;
            state_goto <= daq_ctrl_pkg::MAIN_WAIT;
        end else begin
            state <= next_state;
            case (state)
                daq_ctrl_pkg::READ_WORK:
                    state_goto <= (com.read_btype == daq_cmd_pkg::COM_CONF) ?
                                  daq_ctrl_pkg::CONF_IDLE : daq_ctrl_pkg::MAIN_WAIT;
                // a tick that was already queued when STOP came is acknowledged and dropped
                daq_ctrl_pkg::TICK_WORK:
                    state_goto <= work ? daq_ctrl_pkg::CONV_IDLE : daq_ctrl_pkg::MAIN_WAIT;
                daq_ctrl_pkg::CONF_WORK: state_goto <= daq_ctrl_pkg::SEND_IDLE;
                daq_ctrl_pkg::CONV_WORK: state_goto <= daq_ctrl_pkg::SEND_IDLE;
                daq_ctrl_pkg::SEND_WORK: state_goto <= daq_ctrl_pkg::MAIN_WAIT;
                default: state_goto <= state_goto;
            endcase
        end
    end

    // ****************************************
    // requests and job results
    // ****************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            com.send_req <= 1'b0;
            adc.conf_req <= 1'b0;
            adc.conv_req <= 1'b0;
        end else begin
            if (state == daq_ctrl_pkg::SEND_WORK) com.send_req <= 1'b1;
            else if (state == daq_ctrl_pkg::SEND_DONE) com.send_req <= 1'b0;
            if (state == daq_ctrl_pkg::CONF_WORK) adc.conf_req <= 1'b1;
            else if (state == daq_ctrl_pkg::CONF_DONE) adc.conf_req <= 1'b0;
            if (state == daq_ctrl_pkg::CONV_WORK) adc.conv_req <= 1'b1;
            else if (state == daq_ctrl_pkg::CONV_DONE) adc.conv_req <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            com.send_btype <= daq_cmd_pkg::COM_INIT;
            adc.chan_idx <= 4'hF;  // 15 means no channel converted yet
            work <= 1'b0;
        end else begin
            case (state)
                daq_ctrl_pkg::MAIN_IDLE: begin
                    adc.chan_idx <= 4'hF;
                    work <= 1'b0;
                end
                daq_ctrl_pkg::CONF_IDLE: adc.chan_idx <= 4'hF;
                daq_ctrl_pkg::CONV_IDLE:
                    adc.chan_idx <= (adc.chan_idx >= `DAQ_LAST_CHAN) ? 4'h0 : adc.chan_idx + 4'h1;
                daq_ctrl_pkg::CONF_DONE: com.send_btype <= daq_cmd_pkg::COM_STAT;
                daq_ctrl_pkg::CONV_DONE: com.send_btype <= daq_cmd_pkg::COM_DATA;
                daq_ctrl_pkg::READ_WORK: begin
                    if (com.read_btype == daq_cmd_pkg::COM_READ) work <= 1'b1;
                    else if (com.read_btype == daq_cmd_pkg::COM_STOP) work <= 1'b0;
                    else if (com.read_btype == daq_cmd_pkg::COM_CONF) work <= 1'b0;
                end
                default: work <= work;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- daq_if.sv
`timescale 1ns/1ps
`default_nettype none

// command and reply link between the host frontend and the sequencer
interface com_link_if;
    logic read_req;
    daq_cmd_pkg::btype_e read_btype;
    logic read_done;
    logic send_req;
    daq_cmd_pkg::btype_e send_btype;
    logic [3:0] send_chan;  // channel index that goes with the reply
    logic send_done;

    modport frontend (
        output read_req, read_btype, send_done,
        input read_done, send_req, send_btype, send_chan
    );
    modport console (
        input read_req, read_btype, send_done,
        output read_done, send_req, send_btype, send_chan
    );
endinterface

// configuration and conversion requests towards the ADC sampler
interface adc_ctl_if;
    logic conf_req;
    logic conv_req;
    logic [3:0] chan_idx;
    logic conf_done;
    logic conv_done;

    modport console (output conf_req, conv_req, chan_idx, input conf_done, conv_done);
    modport sampler (input conf_req, conv_req, chan_idx, output conf_done, conv_done);
endinterface

`default_nettype wire

//--- daq_ctrl_pkg.sv
`default_nettype none

package daq_ctrl_pkg;

    // upper nibble names the job, lower nibble the step within it
    typedef enum logic [7:0] {
        MAIN_IDLE = 8'h00, MAIN_WAIT = 8'h01, MAIN_DOOR = 8'h02,
        TICK_IDLE = 8'h10, TICK_WAIT = 8'h11, TICK_WORK = 8'h12, TICK_DONE = 8'h13,
        READ_IDLE = 8'h40, READ_WAIT = 8'h41, READ_WORK = 8'h42, READ_DONE = 8'h43,
        SEND_IDLE = 8'h50, SEND_WAIT = 8'h51, SEND_WORK = 8'h52, SEND_DONE = 8'h53,
        CONF_IDLE = 8'h80, CONF_WAIT = 8'h81, CONF_WORK = 8'h82, CONF_DONE = 8'h83,
        CONV_IDLE = 8'h90, CONV_WAIT = 8'h91, CONV_WORK = 8'h92, CONV_DONE = 8'h93
    } hq_state_e;

    typedef enum logic [3:0] {
        REG_TICK = 4'h0,
        REG_CONF = 4'h4,
        REG_STAT = 4'h8  // read only
    } reg_addr_e;

endpackage

`default_nettype wire

//--- daq_cmd_pkg.sv
`default_nettype none

package daq_cmd_pkg;

    // byte types shared by host commands and replies
    typedef enum logic [3:0] {
        COM_INIT = 4'h0,
        COM_CONF = 4'h1,  // configure the ADC, answered by STAT
        COM_READ = 4'h4,  // start periodic acquisition
        COM_DATA = 4'h5,
        COM_STOP = 4'h9,
        COM_STAT = 4'hA
    } btype_e;

endpackage

`default_nettype wire

//--- daq_consts.svh
`ifndef DAQ_CONSTS_SVH
`define DAQ_CONSTS_SVH

// sample width and the channel sweep of the ADC
`define DAQ_DATA_W 12
`define DAQ_CHANNELS 6
`define DAQ_LAST_CHAN 5

`define DAQ_ADDR_W 4        // AXI4-Lite byte address width
`define DAQ_TICK_DEFAULT 64 // tick period in clock cycles after reset

`endif
